//--- sim.f
mipsPkg.sv
pcUnit.sv
decodeUnit.sv
regFile.sv
execUnit.sv
memAlign.sv
hazardUnit.sv
mipsCore.sv
tbMipsCore.sv

//--- Bender.yml
package:
  name: mipscore

sources:
  - mipsPkg.sv
  - pcUnit.sv
  - decodeUnit.sv
  - regFile.sv
  - execUnit.sv
  - memAlign.sv
  - hazardUnit.sv
  - mipsCore.sv
  - target: simulation
    files:
      - tbMipsCore.sv

//--- tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore import mipsPkg::*; ();

    typedef struct packed {
        wordT    pc;
        regAddrT rd;
        wordT    value;
    } wbExpT;

    localparam int ImemWords = 256;
    localparam int DmemWords = 64;
    localparam int WaitLimit = 40;  // cycles per writeback

    logic       clk;
    logic       rstN;
    wordT       pc, instr, memAddr, memWdata, memRdata;
    logic       instEn, memEn, wbWen;
    logic [3:0] memWe;
    wordT       wbPc, wbData;
    regAddrT    wbReg;

    wordT  imem [ImemWords];
    wordT  dmem [DmemWords];
    wbExpT expQ [$];
    string nameQ [$];
    string grp;
    wordT  at;        // next program address
    int    errors;
    int    checks;
    int    fetchDrops; // cycles with the fetch enable low

    mipsCore i_mipsCore (
        .clk(clk), .rstN_i(rstN), .pc_o(pc), .instEn_o(instEn), .instr_i(instr),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr), .memWdata_o(memWdata),
        .memRdata_i(memRdata), .dbgWbPc_o(wbPc), .dbgWbWen_o(wbWen), .dbgWbReg_o(wbReg),
        .dbgWbData_o(wbData)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // instruction RAM, one cycle read latency
    always @(posedge clk) begin
        if (instEn) instr <= imem[pc[9:2]];
    end

    // data RAM with byte lanes
    always @(posedge clk) begin
        if (memEn) begin
            for (int b = 0; b < 4; b++) begin
                if (memWe[b]) dmem[memAddr[7:2]][8*b +: 8] <= memWdata[8*b +: 8];
            end
            memRdata <= dmem[memAddr[7:2]];
        end
    end

    function automatic wordT fillWord(input int idx);
        return 32'hDA7A_0000 | (idx << 2);  // byte address in the low half
    endfunction

    function automatic wordT rType(input functT fn, input regAddrT rs, input regAddrT rt,
                                   input regAddrT rd, input logic [4:0] sh);
        return {OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic wordT iType(input opcodeT op, input regAddrT rs, input regAddrT rt,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jType(input opcodeT op, input wordT target);
        return {op, target[27:2]};
    endfunction

    task automatic put(input wordT ins);
        imem[at[9:2]] = ins;
        at = at + 32'd4;
    endtask

    task automatic putWb(input wordT ins, input regAddrT rd, input wordT value);
        wbExpT e;
        e.pc    = at;
        e.rd    = rd;
        e.value = value;
        expQ.push_back(e);
        nameQ.push_back(grp);
        put(ins);
    endtask

    // must never reach writeback
    task automatic putWrongPath();
        put(iType(OP_ADDIU, 0, 25, 16'h0BAD));
    endtask

    task automatic loadProgram();
        at  = ResetPc;
        grp = "alu";
        putWb(iType(OP_ADDIU, 0, 1, 16'h1234), 1, 32'h0000_1234);
        putWb(iType(OP_ADDIU, 0, 2, 16'hF0F1), 2, 32'hFFFF_F0F1);
        putWb(rType(FN_ADDU, 1, 2, 3, 0), 3, 32'h0000_0325);   // r2 from E, r1 from M
        putWb(rType(FN_SUBU, 3, 1, 4, 0), 4, 32'hFFFF_F0F1);   // r1 from W
        putWb(rType(FN_AND, 4, 1, 5, 0), 5, 32'h0000_1030);
        putWb(rType(FN_OR, 5, 3, 6, 0), 6, 32'h0000_1335);
        putWb(rType(FN_XOR, 6, 1, 7, 0), 7, 32'h0000_0101);
        putWb(rType(FN_SLT, 2, 7, 8, 0), 8, 32'h1);
        putWb(rType(FN_SLT, 7, 2, 9, 0), 9, 32'h0);
        putWb(iType(OP_SLTI, 2, 10, 16'hFFFF), 10, 32'h1);
        putWb(rType(FN_SLL, 0, 7, 11, 4), 11, 32'h0000_1010);
        putWb(iType(OP_ANDI, 2, 12, 16'hFF0F), 12, 32'h0000_F001);
        putWb(iType(OP_ORI, 1, 13, 16'h8001), 13, 32'h0000_9235);
        putWb(iType(OP_LUI, 0, 14, 16'hBEEF), 14, 32'hBEEF_0000);
        putWb(iType(OP_ADDIU, 14, 15, 16'h7FFF), 15, 32'hBEEF_7FFF);
        grp = "load";
        putWb(iType(OP_ADDIU, 0, 20, 16'h0040), 20, 32'h0000_0040);
        putWb(iType(OP_LW, 20, 16, 16'h0), 16, 32'h817F_C304);
        putWb(rType(FN_ADDU, 16, 0, 17, 0), 17, 32'h817F_C304); // load-use
        putWb(iType(OP_LB, 20, 18, 16'h0), 18, 32'h0000_0004);
        putWb(iType(OP_LB, 20, 18, 16'h1), 18, 32'hFFFF_FFC3);
        putWb(iType(OP_LB, 20, 18, 16'h2), 18, 32'h0000_007F);
        putWb(iType(OP_LB, 20, 18, 16'h3), 18, 32'hFFFF_FF81);
        putWb(iType(OP_LBU, 20, 19, 16'h0), 19, 32'h0000_0004);
        putWb(iType(OP_LBU, 20, 19, 16'h1), 19, 32'h0000_00C3);
        putWb(iType(OP_LBU, 20, 19, 16'h2), 19, 32'h0000_007F);
        putWb(iType(OP_LBU, 20, 19, 16'h3), 19, 32'h0000_0081);
        putWb(iType(OP_ADDIU, 19, 21, 16'h1), 21, 32'h0000_0082);
        grp = "store";
        put(iType(OP_SB, 20, 1, 16'h5));     // lane 1 of 0x44
        put(iType(OP_SB, 20, 7, 16'h7));     // lane 3 of 0x44
        putWb(iType(OP_LW, 20, 22, 16'h4), 22, 32'h0122_3444);
        put(iType(OP_SW, 20, 15, 16'h8));
        put(iType(OP_SB, 20, 13, 16'h8));
        putWb(iType(OP_LW, 20, 23, 16'h8), 23, 32'hBEEF_7F35);
        grp = "branch";
        put(iType(OP_BEQ, 8, 9, 16'd3));     // not taken
        putWb(iType(OP_ADDIU, 0, 24, 16'd1), 24, 32'd1);
        putWb(iType(OP_ADDIU, 24, 24, 16'd2), 24, 32'd3);
        put(iType(OP_BNE, 8, 9, 16'd3));     // taken to 0xa0
        putWb(iType(OP_ADDIU, 0, 25, 16'h55), 25, 32'h55);
        putWrongPath();
        putWrongPath();
        putWb(iType(OP_ADDIU, 25, 26, 16'd1), 26, 32'h56);
        put(iType(OP_BEQ, 26, 26, 16'd3));   // taken, r26 still in E
        putWb(iType(OP_ADDIU, 0, 27, 16'd7), 27, 32'd7);
        putWrongPath();
        putWrongPath();
        put(iType(OP_BNE, 27, 27, 16'd3));
        putWb(iType(OP_ADDIU, 27, 28, 16'd1), 28, 32'd8);
        putWb(iType(OP_ADDIU, 28, 28, 16'd1), 28, 32'd9);
        grp = "jump";
        put(jType(OP_J, 32'h0D0));
        putWb(iType(OP_ADDIU, 0, 29, 16'h11), 29, 32'h11);
        putWrongPath();
        putWrongPath();
        putWb(jType(OP_JAL, 32'h100), 31, 32'h0D8);
        putWb(iType(OP_ADDIU, 0, 30, 16'h22), 30, 32'h22);
        at = 32'h100;
        putWb(rType(FN_ADDU, 31, 0, 3, 0), 3, 32'h0D8);
        put(iType(OP_ADDIU, 0, 0, 16'h0077));    // r0 write, no trace
        putWb(rType(FN_ADDU, 0, 0, 4, 0), 4, 32'h0);
        put(rType(FN_JR, 31, 0, 0, 0));
        putWb(iType(OP_ADDIU, 4, 5, 16'd5), 5, 32'd5);
        putWrongPath();
        at = 32'h0D8;
        putWb(iType(OP_ADDIU, 0, 6, 16'h66), 6, 32'h66);
        putWb(iType(OP_LW, 20, 9, 16'h10), 9, 32'h120);
        put(rType(FN_JR, 9, 0, 0, 0));           // waits out the load
        putWb(iType(OP_ADDIU, 0, 10, 16'h33), 10, 32'h33);
        putWrongPath();
        at = 32'h120;
        putWb(iType(OP_ADDIU, 9, 11, 16'd4), 11, 32'h124);
        put(iType(OP_BEQ, 0, 0, 16'hFFFF));      // park here
        put(32'h0);
    endtask

    task automatic compare(input string name, input wordT expv, input wordT actv);
        checks++;
        if (actv !== expv) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expv, actv);
        end
    endtask

    task automatic waitWb(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < WaitLimit && !seen; n++) begin
            @(negedge clk);
            if (!instEn) fetchDrops++;
            seen = wbWen;
        end
    endtask

    initial begin
        logic seen;
        logic lost;
        errors     = 0;
        checks     = 0;
        fetchDrops = 0;
        lost       = 1'b0;
        rstN       = 1'b0;
        instr      = '0;
        memRdata   = '0;
        for (int i = 0; i < ImemWords; i++) imem[i] = '0;
        for (int i = 0; i < DmemWords; i++) dmem[i] = fillWord(i);
        dmem[16] = 32'h817F_C304;
        dmem[17] = 32'h1122_3344;
        dmem[20] = 32'h0000_0120;   // jr target
        loadProgram();

        repeat (15) @(posedge clk);
        @(negedge clk);
        compare("reset pc", ResetPc, pc);
        compare("reset memEn", 32'(memEn), 32'h0);
        compare("reset memWe", 32'(memWe), 32'h0);
        compare("reset wbWen", 32'(wbWen), 32'h0);
        @(posedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < expQ.size() && !lost; i++) begin
            waitWb(seen);
            if (!seen) begin
                errors++;
                lost = 1'b1;
                $display("writeback %0d of group %s never arrived", i, nameQ[i]);
            end else begin
                compare($sformatf("%s[%0d] pc", nameQ[i], i), expQ[i].pc, wbPc);
                compare($sformatf("%s[%0d] reg", nameQ[i], i), 32'(expQ[i].rd), 32'(wbReg));
                compare($sformatf("%s[%0d] data", nameQ[i], i), expQ[i].value, wbData);
            end
        end

        // parked in the end loop, nothing more should retire
        if (!lost) begin
            // bne at 0x90, beq at 0xa4 and the first pass of the end loop
            compare("taken-branch fetch drops", 32'd3, 32'(fetchDrops));
            for (int n = 0; n < 30; n++) begin
                @(negedge clk);
                if (wbWen) begin
                    errors++;
                    $display("unexpected writeback from pc %h to r%0d", wbPc, wbReg);
                end
            end
        end

        compare("ram 0x40", 32'h817F_C304, dmem[16]);
        compare("ram 0x44", 32'h0122_3444, dmem[17]);
        compare("ram 0x48", 32'hBEEF_7F35, dmem[18]);
        compare("ram 0x4c", fillWord(19), dmem[19]);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- mipsCore.sv
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; (
    input  logic       clk,
    input  logic       rstN_i,
    output wordT       pc_o,
    output logic       instEn_o,
    input  wordT       instr_i,
    output logic       memEn_o,
    output logic [3:0] memWe_o,
    output wordT       memAddr_o,
    output wordT       memWdata_o,
    input  wordT       memRdata_i,
    output wordT       dbgWbPc_o,
    output logic       dbgWbWen_o,
    output regAddrT    dbgWbReg_o,
    output wordT       dbgWbData_o
);

    wordT     pcF2, pcD, instrD, instrHeld, instrF2;
    logic     validF2, heldValid;
    ctrlT     ctrlD;
    wordT     immD, jumpTargetD, branchTargetD, rdA, rdB, rsFwd, rtFwd;
    logic     jumpD, linkD, branchTakenE;
    wordT     aluOutE, loadDataM, resultM;
    fwdSelT   fwdA, fwdB;
    logic     stallF, stallD, flushF2, flushD, flushE;
    exStageT  exStage, exNext;
    memStageT memStage, memNext;
    wbStageT  wbStage, wbNext;

    pcUnit u_pcUnit (.clk, .rstN_i, .stall_i(stallF), .branchTaken_i(branchTakenE),
        .branchTarget_i(exStage.branchTarget), .jump_i(jumpD), .jumpTarget_i(jumpTargetD),
        .pc_o, .instEn_o);

    // F -> F2
    always_ff @(posedge clk) begin
        if (!rstN_i || flushF2) begin
            pcF2    <= '0;
            validF2 <= 1'b0;
        end else if (!stallF) begin
            pcF2    <= pc_o;
            validF2 <= instEn_o;
        end
    end

    // the RAM moves on during a stall, so keep the word it returned
    always_ff @(posedge clk) begin
        if (!rstN_i) heldValid <= 1'b0;
        else         heldValid <= stallD;
    end

    always_ff @(posedge clk) begin
        if (stallD && !heldValid) instrHeld <= instr_i;
    end

    assign instrF2 = validF2 ? (heldValid ? instrHeld : instr_i) : '0;

    // F2 -> D
    always_ff @(posedge clk) begin
        if (!rstN_i || flushD) begin
            pcD    <= '0;
            instrD <= '0;
        end else if (!stallD) begin
            pcD    <= pcF2;
            instrD <= instrF2;
        end
    end

    regFile u_regFile (.clk, .rstN_i, .we_i(wbStage.regWrite), .waddr_i(wbStage.writeReg),
        .wdata_i(wbStage.result), .raddrA_i(instrD[25:21]), .raddrB_i(instrD[20:16]),
        .rdataA_o(rdA), .rdataB_o(rdB));

    function automatic wordT fwdMux(input fwdSelT sel, input wordT rf);
        case (sel)
            FWD_E:   return aluOutE;
            FWD_M:   return resultM;
            FWD_W:   return wbStage.result;
            default: return rf;
        endcase
    endfunction

    assign rsFwd = fwdMux(fwdA, rdA);
    assign rtFwd = fwdMux(fwdB, rdB);

    decodeUnit u_decodeUnit (.instr_i(instrD), .pc_i(pcD), .rsValue_i(rsFwd), .ctrl_o(ctrlD),
        .imm_o(immD), .jump_o(jumpD), .jumpTarget_o(jumpTargetD),
        .branchTarget_o(branchTargetD), .link_o(linkD));

    always_comb begin
        exNext.pc           = pcD;
        exNext.ctrl         = ctrlD;
        exNext.srcA         = linkD ? pcD + 32'd8 : rsFwd;
        exNext.srcB         = linkD ? '0 : (ctrlD.useImm ? immD : rtFwd);
        exNext.rtValue      = rtFwd;
        exNext.shamt        = instrD[10:6];
        exNext.branchTarget = branchTargetD;
    end

    hazardUnit u_hazardUnit (.rsD_i(instrD[25:21]), .rtD_i(instrD[20:16]),
        .writeRegE_i(exStage.ctrl.writeReg), .writeRegM_i(memStage.writeReg),
        .writeRegW_i(wbStage.writeReg), .regWriteE_i(exStage.ctrl.regWrite),
        .regWriteM_i(memStage.regWrite), .regWriteW_i(wbStage.regWrite),
        .memReadE_i(exStage.ctrl.memRead), .branchTakenE_i(branchTakenE), .jumpD_i(jumpD),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .stallF_o(stallF), .stallD_o(stallD),
        .flushF2_o(flushF2), .flushD_o(flushD), .flushE_o(flushE));

    // D -> E, E -> M, M -> W
    always_ff @(posedge clk) begin
        if (!rstN_i || flushE) exStage <= '0;
        else                   exStage <= exNext;
    end

    execUnit u_execUnit (.stage_i(exStage), .aluOut_o(aluOutE), .branchTaken_o(branchTakenE));

    memAlign u_memAlign (.addrLowE_i(aluOutE[1:0]), .sizeE_i(exStage.ctrl.memSize),
        .storeE_i(exStage.ctrl.memWrite), .rtValueE_i(exStage.rtValue), .we_o(memWe_o),
        .wdata_o(memWdata_o), .addrLowM_i(memStage.addrLow), .sizeM_i(memStage.memSize),
        .signedM_i(memStage.loadSigned), .rdata_i(memRdata_i), .loadData_o(loadDataM));

    assign memEn_o   = exStage.ctrl.memRead | exStage.ctrl.memWrite;
    assign memAddr_o = aluOutE;

    assign memNext = '{pc: exStage.pc, regWrite: exStage.ctrl.regWrite,
                       memRead: exStage.ctrl.memRead, memSize: exStage.ctrl.memSize,
                       loadSigned: exStage.ctrl.loadSigned, writeReg: exStage.ctrl.writeReg,
                       aluOut: aluOutE, addrLow: aluOutE[1:0]};

    always_ff @(posedge clk) begin
        if (!rstN_i) memStage <= '0;
        else         memStage <= memNext;
    end

    assign resultM = memStage.memRead ? loadDataM : memStage.aluOut;
    assign wbNext  = '{pc: memStage.pc, regWrite: memStage.regWrite,
                       writeReg: memStage.writeReg, result: resultM};

    always_ff @(posedge clk) begin
        if (!rstN_i) wbStage <= '0;
        else         wbStage <= wbNext;
    end

    assign dbgWbPc_o   = wbStage.pc;
    assign dbgWbWen_o  = wbStage.regWrite && wbStage.writeReg != '0; // r0 writes hidden
    assign dbgWbReg_o  = wbStage.writeReg;
    assign dbgWbData_o = wbStage.result;
endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
    input  regAddrT rsD_i,
    input  regAddrT rtD_i,
    input  regAddrT writeRegE_i,
    input  regAddrT writeRegM_i,
    input  regAddrT writeRegW_i,
    input  logic    regWriteE_i,
    input  logic    regWriteM_i,
    input  logic    regWriteW_i,
    input  logic    memReadE_i,
    input  logic    branchTakenE_i,
    input  logic    jumpD_i,
    output fwdSelT  fwdA_o,
    output fwdSelT  fwdB_o,
    output logic    stallF_o,
    output logic    stallD_o,
    output logic    flushF2_o,
    output logic    flushD_o,
    output logic    flushE_o
);

    logic loadUse;

    // youngest producer wins, a load in E has no data yet
    function automatic fwdSelT pickSrc(input regAddrT src);
        if (src == '0) return FWD_RF;
        if (regWriteE_i && writeRegE_i == src && !memReadE_i) return FWD_E;
        if (regWriteM_i && writeRegM_i == src) return FWD_M;
        if (regWriteW_i && writeRegW_i == src) return FWD_W;
        return FWD_RF;
    endfunction

    assign fwdA_o = pickSrc(rsD_i);
    assign fwdB_o = pickSrc(rtD_i);

    assign loadUse = memReadE_i && writeRegE_i != '0 &&
                     (writeRegE_i == rsD_i || writeRegE_i == rtD_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushE_o = loadUse;  // bubble into E while D waits

    // taken branch kills F and F2, the delay slot in D survives
    // a jump only kills F, and must wait out a stall first
    assign flushF2_o = branchTakenE_i || (jumpD_i && !loadUse);
    assign flushD_o  = branchTakenE_i;
endmodule

//--- memAlign.sv
`timescale 1ns/1ps

module memAlign import mipsPkg::*; (
    input  logic [1:0] addrLowE_i,
    input  memSizeT    sizeE_i,
    input  logic       storeE_i,
    input  wordT       rtValueE_i,
    output logic [3:0] we_o,
    output wordT       wdata_o,
    input  logic [1:0] addrLowM_i,
    input  memSizeT    sizeM_i,
    input  logic       signedM_i,
    input  wordT       rdata_i,
    output wordT       loadData_o
);

    logic [7:0] loadByte;

    // store side, execute stage
    always_comb begin
        if (!storeE_i)                we_o = 4'b0000;
        else if (sizeE_i == MEM_WORD) we_o = 4'b1111;
        else                          we_o = 4'b0001 << addrLowE_i; // little-endian lane
    end

    assign wdata_o = (sizeE_i == MEM_WORD) ? rtValueE_i : {4{rtValueE_i[7:0]}};

    // load side, memory stage
    assign loadByte = rdata_i[8*addrLowM_i +: 8];

    always_comb begin
        if (sizeM_i == MEM_WORD) loadData_o = rdata_i;
        else if (signedM_i)      loadData_o = {{24{loadByte[7]}}, loadByte};
        else                     loadData_o = {24'b0, loadByte};
    end
endmodule

//--- execUnit.sv
`timescale 1ns/1ps

module execUnit import mipsPkg::*; (
    input  exStageT stage_i,
    output wordT    aluOut_o,
    output logic    branchTaken_o
);

    wordT a;
    wordT b;
    logic equal;

    assign a = stage_i.srcA;
    assign b = stage_i.srcB;

    always_comb begin
        case (stage_i.ctrl.aluOp)
            ALU_ADD: aluOut_o = a + b;        // also carries jal link value
            ALU_SUB: aluOut_o = a - b;
            ALU_AND: aluOut_o = a & b;
            ALU_OR:  aluOut_o = a | b;
            ALU_XOR: aluOut_o = a ^ b;
            ALU_SLT: aluOut_o = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: aluOut_o = b << stage_i.shamt;
            ALU_LUI: aluOut_o = {b[15:0], 16'b0};
            default: aluOut_o = '0;
        endcase
    end

    // beq when equal, bne when not
    assign equal         = (stage_i.srcA == stage_i.rtValue);
    assign branchTaken_o = stage_i.ctrl.isBranch && (equal != stage_i.ctrl.branchNe);
endmodule

//--- regFile.sv
`timescale 1ns/1ps

module regFile import mipsPkg::*; (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    we_i,
    input  regAddrT waddr_i,
    input  wordT    wdata_i,
    input  regAddrT raddrA_i,
    input  regAddrT raddrB_i,
    output wordT    rdataA_o,
    output wordT    rdataB_o
);

    wordT regs [1:NumRegs-1]; // r0 not stored

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    function automatic wordT readPort(input regAddrT addr);
        if (addr == '0)                 return '0;
        if (we_i && waddr_i == addr)    return wdata_i; // same-cycle write-through
        return regs[addr];
    endfunction

    assign rdataA_o = readPort(raddrA_i);
    assign rdataB_o = readPort(raddrB_i);
endmodule

//--- decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit import mipsPkg::*; (
    input  wordT instr_i,
    input  wordT pc_i,
    input  wordT rsValue_i,
    output ctrlT ctrl_o,
    output wordT imm_o,
    output logic jump_o,
    output wordT jumpTarget_o,
    output wordT branchTarget_o,
    output logic link_o
);

    opcodeT  op;
    functT   funct;
    regAddrT rtF;
    regAddrT rdF;
    wordT    pcPlus4;
    wordT    immSext;
    logic    signExt;

    assign op      = opcodeT'(instr_i[31:26]);
    assign funct   = functT'(instr_i[5:0]);
    assign rtF     = instr_i[20:16];
    assign rdF     = instr_i[15:11];
    assign pcPlus4 = pc_i + 32'd4;
    assign immSext = {{16{instr_i[15]}}, instr_i[15:0]};

    always_comb begin
        ctrl_o       = '0;  // nop unless recognised
        ctrl_o.writeReg = rtF;
        signExt      = 1'b1;
        jump_o       = 1'b0;
        link_o       = 1'b0;
        jumpTarget_o = {pcPlus4[31:28], instr_i[25:0], 2'b00};
        case (op)
            OP_SPECIAL: begin
                ctrl_o.writeReg = rdF;
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    FN_SLL:  ctrl_o.aluOp = ALU_SLL;
                    FN_ADDU: ctrl_o.aluOp = ALU_ADD;
                    FN_SUBU: ctrl_o.aluOp = ALU_SUB;
                    FN_AND:  ctrl_o.aluOp = ALU_AND;
                    FN_OR:   ctrl_o.aluOp = ALU_OR;
                    FN_XOR:  ctrl_o.aluOp = ALU_XOR;
                    FN_SLT:  ctrl_o.aluOp = ALU_SLT;
                    FN_JR: begin
                        ctrl_o.regWrite = 1'b0;
                        jump_o          = 1'b1;
                        jumpTarget_o    = rsValue_i; // forwarded rs
                    end
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: {ctrl_o.regWrite, ctrl_o.useImm, ctrl_o.aluOp} = {2'b11, ALU_ADD};
            OP_SLTI:  {ctrl_o.regWrite, ctrl_o.useImm, ctrl_o.aluOp} = {2'b11, ALU_SLT};
            OP_ANDI: begin
                {ctrl_o.regWrite, ctrl_o.useImm, ctrl_o.aluOp} = {2'b11, ALU_AND};
                signExt = 1'b0;
            end
            OP_ORI: begin
                {ctrl_o.regWrite, ctrl_o.useImm, ctrl_o.aluOp} = {2'b11, ALU_OR};
                signExt = 1'b0;
            end
            OP_LUI: begin
                {ctrl_o.regWrite, ctrl_o.useImm, ctrl_o.aluOp} = {2'b11, ALU_LUI};
                signExt = 1'b0;
            end
            OP_LB, OP_LBU, OP_LW: begin
                {ctrl_o.regWrite, ctrl_o.memRead, ctrl_o.useImm} = 3'b111;
                ctrl_o.memSize    = (op == OP_LW) ? MEM_WORD : MEM_BYTE;
                ctrl_o.loadSigned = (op == OP_LB);
            end
            OP_SB, OP_SW: begin
                {ctrl_o.memWrite, ctrl_o.useImm} = 2'b11;
                ctrl_o.memSize = (op == OP_SW) ? MEM_WORD : MEM_BYTE;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.isBranch = 1'b1;
                ctrl_o.branchNe = (op == OP_BNE);
            end
            OP_J:   jump_o = 1'b1;
            OP_JAL: begin
                jump_o          = 1'b1;
                link_o          = 1'b1;  // pc+8 rides through the ALU
                ctrl_o.regWrite = 1'b1;
                ctrl_o.writeReg = 5'd31;
            end
            default: ;
        endcase
    end

    assign imm_o          = signExt ? immSext : {16'b0, instr_i[15:0]};
    assign branchTarget_o = pcPlus4 + {immSext[29:0], 2'b00};
endmodule

//--- pcUnit.sv
`timescale 1ns/1ps

module pcUnit import mipsPkg::*; (
    input  logic clk,
    input  logic rstN_i,
    input  logic stall_i,
    input  logic branchTaken_i,
    input  wordT branchTarget_i,
    input  logic jump_i,
    input  wordT jumpTarget_i,
    output wordT pc_o,
    output logic instEn_o
);

    wordT pcQ;
    wordT pcNext;

    // branch from E beats the load-use hold, which beats a jump from D
    always_comb begin
        if (branchTaken_i) pcNext = branchTarget_i;
        else if (stall_i)  pcNext = pcQ;
        else if (jump_i)   pcNext = jumpTarget_i;
        else               pcNext = pcQ + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) pcQ <= ResetPc;
        else         pcQ <= pcNext;
    end

    assign pc_o     = pcQ;
    assign instEn_o = ~branchTaken_i; // wrong-path fetch dropped
endmodule

//--- mipsPkg.sv
package mipsPkg;

    localparam int DataW    = 32;
    localparam int RegAddrW = 5;
    localparam int NumRegs  = 32;
    localparam logic [DataW-1:0] ResetPc = 32'h0000_0000;

    typedef logic [DataW-1:0]    wordT;
    typedef logic [RegAddrW-1:0] regAddrT;

    // major opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_J    = 6'h02, OP_JAL  = 6'h03, OP_BEQ = 6'h04,
        OP_BNE     = 6'h05, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c,
        OP_ORI     = 6'h0d, OP_LUI  = 6'h0f, OP_LB   = 6'h20, OP_LW  = 6'h23,
        OP_LBU     = 6'h24, OP_SB   = 6'h28, OP_SW   = 6'h2b
    } opcodeT;

    // SPECIAL function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_JR  = 6'h08, FN_ADDU = 6'h21, FN_SUBU = 6'h23,
        FN_AND = 6'h24, FN_OR  = 6'h25, FN_XOR  = 6'h26, FN_SLT  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {FWD_RF, FWD_W, FWD_M, FWD_E} fwdSelT;

    typedef enum logic {MEM_BYTE, MEM_WORD} memSizeT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        memSizeT memSize;
        logic    loadSigned;
        aluOpT   aluOp;
        logic    useImm;
        logic    isBranch;
        logic    branchNe;
        regAddrT writeReg;
    } ctrlT;

    typedef struct packed {
        wordT       pc;
        ctrlT       ctrl;
        wordT       srcA;
        wordT       srcB;          // imm already muxed in when useImm
        wordT       rtValue;
        logic [4:0] shamt;
        wordT       branchTarget;
    } exStageT;

    typedef struct packed {
        wordT       pc;
        logic       regWrite;
        logic       memRead;
        memSizeT    memSize;
        logic       loadSigned;
        regAddrT    writeReg;
        wordT       aluOut;
        logic [1:0] addrLow;
    } memStageT;

    typedef struct packed {
        wordT    pc;
        logic    regWrite;
        regAddrT writeReg;
        wordT    result;
    } wbStageT;

endpackage
